/* Bender.yml */
package:
  name: command_handler

sources:
  - files:
      - terminal_pkg.sv
      - terminal_if.sv
      - command_decoder.sv
      - cursor_tracker.sv
      - screen_writer.sv
      - command_handler.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_command_handler.sv

/* command_decoder.sv */
// command decoder: parses the byte stream and escape sequences into cursor commands
module command_decoder import terminal_pkg::*; #(
   parameter int rows = 25,
   parameter int cols = 80
) (
   input  logic         clk,
   input  logic         clr,
   input  logic         px_clk,
   input  logic [7:0]   data,
   input  logic         valid,
   output logic         ready,
   cursor_cmd_if.source cmd,
   input  logic         wr_busy
);
   localparam int row_bits = $clog2(rows);
   localparam int col_bits = $clog2(cols);

   dec_state_t          state;
   logic                accept;
   logic                printable;
   logic                row_in_range;
   logic                col_in_range;
   logic [row_bits-1:0] row_q;
   logic                row_ok_q;

   // char memory runs at half rate and erase runs block new bytes
   assign ready  = ~px_clk & ~wr_busy;
   assign accept = ready & valid;

   assign printable    = (data >= char_first_print) && (data <= char_last_print);
   assign row_in_range = (data >= pos_offset) && (int'(data) < int'(pos_offset) + rows);
   assign col_in_range = (data >= pos_offset) && (int'(data) < int'(pos_offset) + cols);

   always_comb begin
      cmd.strobe = 1'b0;
      cmd.op     = op_put;
      cmd.ch     = data;
      cmd.row    = row_q;
      cmd.row_ok = row_ok_q;
      // out of range column goes to the last column
      cmd.col    = col_in_range ? col_bits'(data - pos_offset) : col_bits'(cols - 1);
      if (accept) begin
         case (state)
            st_char: begin
               if (printable) begin
                  cmd.strobe = 1'b1;
                  cmd.op     = op_put;
               end else begin
                  case (data)
                     char_bs: begin
                        cmd.strobe = 1'b1;
                        cmd.op     = op_bs;
                     end
                     char_cr: begin
                        cmd.strobe = 1'b1;
                        cmd.op     = op_cr;
                     end
                     char_lf: begin
                        cmd.strobe = 1'b1;
                        cmd.op     = op_lf;
                     end
                     default: ;
                  endcase
               end
            end
            st_esc: begin
               cmd.strobe = 1'b1;
               case (data)
                  "A":     cmd.op = op_up;
                  "B":     cmd.op = op_down;
                  "C":     cmd.op = op_right;
                  "D":     cmd.op = op_left;
                  "H":     cmd.op = op_home;
                  "K":     cmd.op = op_erase_line;
                  "J":     cmd.op = op_erase_screen;
                  // Y, a second esc and unknown codes issue nothing here
                  default: cmd.strobe = 1'b0;
               endcase
            end
            st_col: begin
               cmd.strobe = 1'b1;
               cmd.op     = op_goto;
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         state <= st_char;
      end else if (accept) begin
         case (state)
            st_char: begin
               if (data == char_esc) begin
                  state <= st_esc;
               end
            end
            st_esc: begin
               // a double escape keeps us in escape mode
               if (data == "Y") begin
                  state <= st_row;
               end else if (data != char_esc) begin
                  state <= st_char;
               end
            end
            st_row:  state <= st_col;
            default: state <= st_char;
         endcase
      end
   end

   // row argument is held until the column byte shows up
   always_ff @(posedge clk) begin
      if (accept && state == st_row) begin
         row_q    <= row_bits'(data - pos_offset);
         row_ok_q <= row_in_range;
      end
   end

endmodule

/* command_handler.sv */
// command handler: VT52-style byte stream to character memory, cursor and scroll updates
module command_handler #(
   parameter int  rows = 25,
   parameter int  cols = 80,
   localparam int row_bits  = $clog2(rows),
   localparam int col_bits  = $clog2(cols),
   localparam int addr_bits = $clog2(rows * cols)
) (
   input  logic                 clk,
   input  logic                 clr,
   input  logic                 px_clk,
   input  logic [7:0]           data,
   input  logic                 valid,
   output logic                 ready,
   output logic [7:0]           new_char,
   output logic [addr_bits-1:0] new_char_address,
   output logic                 new_char_wen,
   output logic [col_bits-1:0]  new_cursor_x,
   output logic [row_bits-1:0]  new_cursor_y,
   output logic                 new_cursor_wen,
   output logic [addr_bits-1:0] new_first_char,
   output logic                 new_first_char_wen
);

   cursor_cmd_if   #(.rows(rows), .cols(cols)) cmd_bus ();
   screen_write_if #(.rows(rows), .cols(cols)) wr_bus ();

   command_decoder #(.rows(rows), .cols(cols)) u_decoder (
      .clk     (clk),
      .clr     (clr),
      .px_clk  (px_clk),
      .data    (data),
      .valid   (valid),
      .ready   (ready),
      .cmd     (cmd_bus.source),
      .wr_busy (wr_bus.busy)
   );

   cursor_tracker #(.rows(rows), .cols(cols)) u_tracker (
      .clk            (clk),
      .clr            (clr),
      .px_clk         (px_clk),
      .cmd            (cmd_bus.sink),
      .wr             (wr_bus.source),
      .cursor_x       (new_cursor_x),
      .cursor_y       (new_cursor_y),
      .cursor_wen     (new_cursor_wen),
      .first_char     (new_first_char),
      .first_char_wen (new_first_char_wen)
   );

   screen_writer #(.rows(rows), .cols(cols)) u_writer (
      .clk       (clk),
      .clr       (clr),
      .px_clk    (px_clk),
      .wr        (wr_bus.sink),
      .char_out  (new_char),
      .char_addr (new_char_address),
      .char_wen  (new_char_wen)
   );

endmodule

/* cursor_tracker.sv */
// cursor tracker: keeps cursor, row and char addresses and scroll origin, requests writes
module cursor_tracker import terminal_pkg::*; #(
   parameter int  rows = 25,
   parameter int  cols = 80,
   localparam int row_bits  = $clog2(rows),
   localparam int col_bits  = $clog2(cols),
   localparam int addr_bits = $clog2(rows * cols)
) (
   input  logic                 clk,
   input  logic                 clr,
   input  logic                 px_clk,
   cursor_cmd_if.sink           cmd,
   screen_write_if.source       wr,
   output logic [col_bits-1:0]  cursor_x,
   output logic [row_bits-1:0]  cursor_y,
   output logic                 cursor_wen,
   output logic [addr_bits-1:0] first_char,
   output logic                 first_char_wen
);
   localparam int ext_bits = addr_bits + 1;

   localparam logic [addr_bits-1:0] buf_last = addr_bits'(rows * cols - 1);
   localparam logic [addr_bits-1:0] last_row = addr_bits'((rows - 1) * cols);
   localparam logic [addr_bits-1:0] cols_a   = addr_bits'(cols);
   localparam logic [addr_bits-1:0] row_span = addr_bits'(cols - 1);
   localparam logic [col_bits-1:0]  last_col = col_bits'(cols - 1);
   localparam logic [row_bits-1:0]  last_y   = row_bits'(rows - 1);
   localparam logic [ext_bits-1:0]  buf_size = ext_bits'(rows * cols);

   logic [addr_bits-1:0] row_addr;
   logic [addr_bits-1:0] char_addr;
   logic [addr_bits-1:0] row_down;
   logic [addr_bits-1:0] row_up;
   logic [addr_bits-1:0] origin_next;
   logic [addr_bits-1:0] x_ext;
   logic [row_bits-1:0]  goto_y;
   logic [ext_bits-1:0]  goto_sum;
   logic [addr_bits-1:0] goto_row;
   logic                 at_bottom;

   assign x_ext     = addr_bits'(cursor_x);
   assign at_bottom = (cursor_y == last_y);

   // row addresses are multiples of cols, so a single compare handles the wrap
   assign row_down    = (row_addr == last_row) ? '0 : row_addr + cols_a;
   assign row_up      = (row_addr == '0) ? last_row : row_addr - cols_a;
   assign origin_next = (first_char == last_row) ? '0 : first_char + cols_a;

   // absolute row address for esc Y, wraps at most once
   assign goto_y   = cmd.row_ok ? cmd.row : cursor_y;
   assign goto_sum = ext_bits'(first_char) + ext_bits'(goto_y) * ext_bits'(cols);
   assign goto_row = (goto_sum >= buf_size) ? addr_bits'(goto_sum - buf_size)
                                            : addr_bits'(goto_sum);

   always_comb begin
      wr.start = 1'b0;
      wr.ch    = char_space;
      wr.first = char_addr;
      wr.last  = char_addr;
      if (cmd.strobe) begin
         case (cmd.op)
            op_put: begin
               wr.start = 1'b1;
               wr.ch    = cmd.ch;
            end
            op_lf: begin
               // scrolling blanks the old top row, which becomes the new bottom
               if (at_bottom) begin
                  wr.start = 1'b1;
                  wr.first = first_char;
                  wr.last  = first_char + row_span;
               end
            end
            op_erase_line: begin
               wr.start = 1'b1;
               wr.last  = row_addr + row_span;
            end
            op_erase_screen: begin
               wr.start = 1'b1;
               wr.last  = (first_char == '0) ? buf_last : first_char - 1'b1;
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         cursor_x       <= '0;
         cursor_y       <= '0;
         cursor_wen     <= 1'b0;
         first_char     <= '0;
         first_char_wen <= 1'b0;
         row_addr       <= '0;
         char_addr      <= '0;
      end else if (px_clk) begin
         // display side has latched the values by now
         cursor_wen     <= 1'b0;
         first_char_wen <= 1'b0;
      end else if (cmd.strobe) begin
         case (cmd.op)
            op_put, op_right: begin
               // no auto-wrap, the last column gets overwritten
               if (cursor_x != last_col) begin
                  cursor_x   <= cursor_x + 1'b1;
                  char_addr  <= char_addr + 1'b1;
                  cursor_wen <= 1'b1;
               end
            end
            op_bs, op_left: begin
               if (cursor_x != '0) begin
                  cursor_x   <= cursor_x - 1'b1;
                  char_addr  <= char_addr - 1'b1;
                  cursor_wen <= 1'b1;
               end
            end
            op_cr: begin
               if (cursor_x != '0) begin
                  cursor_x   <= '0;
                  char_addr  <= row_addr;
                  cursor_wen <= 1'b1;
               end
            end
            op_lf: begin
               row_addr  <= row_down;
               char_addr <= row_down + x_ext;
               if (at_bottom) begin
                  first_char     <= origin_next;
                  first_char_wen <= 1'b1;
               end else begin
                  cursor_y   <= cursor_y + 1'b1;
                  cursor_wen <= 1'b1;
               end
            end
            op_down: begin
               if (!at_bottom) begin
                  cursor_y   <= cursor_y + 1'b1;
                  row_addr   <= row_down;
                  char_addr  <= row_down + x_ext;
                  cursor_wen <= 1'b1;
               end
            end
            op_up: begin
               if (cursor_y != '0) begin
                  cursor_y   <= cursor_y - 1'b1;
                  row_addr   <= row_up;
                  char_addr  <= row_up + x_ext;
                  cursor_wen <= 1'b1;
               end
            end
            op_home: begin
               cursor_x   <= '0;
               cursor_y   <= '0;
               row_addr   <= first_char;
               char_addr  <= first_char;
               cursor_wen <= 1'b1;
            end
            op_goto: begin
               cursor_x   <= cmd.col;
               cursor_y   <= goto_y;
               row_addr   <= goto_row;
               char_addr  <= goto_row + addr_bits'(cmd.col);
               cursor_wen <= 1'b1;
            end
            default: ;
         endcase
      end
   end

endmodule

/* screen_writer.sv */
// screen writer: writes a single character or a run of cells into character memory
module screen_writer #(
   parameter int  rows = 25,
   parameter int  cols = 80,
   localparam int addr_bits = $clog2(rows * cols)
) (
   input  logic                 clk,
   input  logic                 clr,
   input  logic                 px_clk,
   screen_write_if.sink         wr,
   output logic [7:0]           char_out,
   output logic [addr_bits-1:0] char_addr,
   output logic                 char_wen
);
   localparam logic [addr_bits-1:0] buf_last = addr_bits'(rows * cols - 1);

   logic                 active;
   logic [addr_bits-1:0] run_last;
   logic [addr_bits-1:0] addr_next;

   // circular buffer, step past the end back to 0
   assign addr_next = (char_addr == buf_last) ? '0 : char_addr + 1'b1;
   assign wr.busy   = active;

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         char_wen <= 1'b0;
         active   <= 1'b0;
      end else if (wr.start) begin
         char_wen <= 1'b1;
         active   <= (wr.first != wr.last);
      end else if (px_clk) begin
         char_wen <= 1'b0;
      end else if (active) begin
         // one cell per px_clk low phase until the last one is out
         char_wen <= 1'b1;
         active   <= (addr_next != run_last);
      end
   end

   always_ff @(posedge clk) begin
      if (wr.start) begin
         char_out  <= wr.ch;
         char_addr <= wr.first;
         run_last  <= wr.last;
      end else if (!px_clk && active) begin
         char_addr <= addr_next;
      end
   end

endmodule

/* sources.f */
+incdir+.
terminal_pkg.sv
terminal_if.sv
command_decoder.sv
cursor_tracker.sv
screen_writer.sv
command_handler.sv
tb_command_handler.sv

/* tb_tests.svh */
// test sequences for the command handler testbench
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

   task automatic run_tests();
      begin_test("reset state");
      @(negedge clk);
      #1;
      check_eq("char wen", new_char_wen, 0);
      check_eq("cursor wen", new_cursor_wen, 0);
      check_eq("first char wen", new_first_char_wen, 0);
      check_eq("ready", ready, !px_clk);
      check_state();
      end_test();

      // 20 bytes on a 16 column row, the last column is overwritten
      begin_test("printable characters");
      repeat (10) put_char(8'(char_first_print + $urandom % 95));
      check_state();
      repeat (10) put_char(8'(char_first_print + $urandom % 95));
      check_state();
      end_test();

      begin_test("cursor movement");
      control(char_cr);
      repeat (3) escape("C");
      repeat (2) escape("B");
      escape("D");
      control(char_bs);
      check_state();
      repeat (5) escape("A");
      repeat (3) escape("D");
      control(char_bs);
      repeat (20) escape("C");
      repeat (6) escape("B");
      check_state();
      // double escape, unknown escape code, ignored control byte
      send_byte(char_esc);
      escape("H");
      escape("Z");
      send_byte(8'h01);
      check_state();
      end_test();

      begin_test("escape Y");
      go_to(8'h22, 8'h25);
      put_char("a");
      go_to(8'h30, 8'h7f);
      check_state();
      put_char("b");
      go_to(8'h1f, 8'h21);
      put_char("c");
      check_state();
      end_test();

      begin_test("linefeed scroll");
      go_to(8'h21, 8'h24);
      control(char_lf);
      check_state();
      control(char_lf);
      repeat (5) control(char_lf);
      check_state();
      // origin is now 16, so this address wraps
      go_to(8'h23, 8'h22);
      put_char("w");
      check_state();
      end_test();

      begin_test("erase line and screen");
      go_to(8'h21, 8'h2a);
      escape("K");
      check_state();
      go_to(8'h22, 8'h23);
      escape("J");
      check_state();
      escape("H");
      escape("J");
      check_state();
      end_test();
   endtask

`endif

/* tb_command_handler.sv */
// testbench for the VT52-style command handler with a screen and cursor model
module tb_command_handler import terminal_pkg::*; ();

   localparam int rows      = 4;
   localparam int cols      = 16;
   localparam int cells     = rows * cols;
   localparam int addr_bits = $clog2(cells);

   logic                 clk;
   logic                 clr;
   logic                 px_clk;
   logic [7:0]           data;
   logic                 valid;
   logic                 ready;
   logic [7:0]           new_char;
   logic [addr_bits-1:0] new_char_address;
   logic                 new_char_wen;
   logic [3:0]           new_cursor_x;
   logic [1:0]           new_cursor_y;
   logic                 new_cursor_wen;
   logic [addr_bits-1:0] new_first_char;
   logic                 new_first_char_wen;

   // cells seen on the write port and cells the model predicts
   logic [7:0] screen [cells];
   logic [7:0] expect_screen [cells];

   // model cursor and scroll origin
   int    mx = 0;
   int    my = 0;
   int    morigin = 0;
   // cursor as the display would latch it on new_cursor_wen
   int    shown_x = 0;
   int    shown_y = 0;
   int    writes_seen = 0;
   int    writes_expected = 0;
   int    scrolls_seen = 0;
   int    scrolls_expected = 0;
   int    bytes_sent = 0;
   int    erase_cells = 0;
   int    cycle_count = 0;
   int    errors = 0;
   int    test_errors = 0;
   int    tests_run = 0;
   int    tests_failed = 0;
   string test_name;

   command_handler #(.rows(rows), .cols(cols)) uut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // px_clk runs at half the clock rate
   always @(negedge clk) begin
      if (clr) begin
         px_clk <= 1'b0;
      end else begin
         px_clk <= ~px_clk;
      end
   end

   // write enables last one clock, so each negedge sees a write at most once
   always @(negedge clk) begin
      if (new_char_wen) begin
         screen[new_char_address] = new_char;
         writes_seen++;
      end
      if (new_cursor_wen) begin
         shown_x = new_cursor_x;
         shown_y = new_cursor_y;
      end
      if (new_first_char_wen) begin
         scrolls_seen++;
      end
   end

   assert property (@(posedge clk) disable iff (clr) px_clk |-> !ready)
   else begin
      errors++;
      test_errors++;
      $display("error @%0t: ready is high while px_clk is high", $time);
   end

   assert property (@(posedge clk) disable iff (clr)
      px_clk |=> !(new_char_wen || new_cursor_wen || new_first_char_wen))
   else begin
      errors++;
      test_errors++;
      $display("error @%0t: a write enable stayed high after a px_clk high clock", $time);
   end

   task automatic check_eq(input string what, input int got, input int want);
      assert (got == want)
      else begin
         errors++;
         test_errors++;
         $display("MISMATCH @%0t: %s is %0d, expected %0d", $time, what, got, want);
      end
   endtask

   task automatic check_state();
      check_eq("cursor x", new_cursor_x, mx);
      check_eq("cursor y", new_cursor_y, my);
      check_eq("latched cursor x", shown_x, mx);
      check_eq("latched cursor y", shown_y, my);
      check_eq("first char", new_first_char, morigin);
      check_eq("char writes", writes_seen, writes_expected);
      check_eq("scrolls", scrolls_seen, scrolls_expected);
      for (int a = 0; a < cells; a++) begin
         check_eq($sformatf("cell %0d", a), screen[a], expect_screen[a]);
      end
   endtask

   function automatic int cursor_addr();
      return (morigin + my * cols + mx) % cells;
   endfunction

   // space run in the model, wrapping at the end of the buffer
   task automatic blank_run(input int start, input int count);
      for (int i = 0; i < count; i++) begin
         expect_screen[(start + i) % cells] = char_space;
      end
      writes_expected += count;
      erase_cells += count;
   endtask

   // hold the byte until accepted, then wait until the DUT takes bytes again
   task automatic send_byte(input logic [7:0] b);
      @(negedge clk);
      data  = b;
      valid = 1'b1;
      #1;
      while (!ready) begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      valid = 1'b0;
      #1;
      while (!ready) begin
         @(negedge clk);
         #1;
      end
      bytes_sent++;
   endtask

   task automatic put_char(input logic [7:0] ch);
      expect_screen[cursor_addr()] = ch;
      writes_expected++;
      if (mx < cols - 1) begin
         mx++;
      end
      send_byte(ch);
   endtask

   task automatic control(input logic [7:0] ch);
      case (ch)
         char_bs: if (mx > 0) mx--;
         char_cr: mx = 0;
         char_lf: begin
            if (my < rows - 1) begin
               my++;
            end else begin
               blank_run(morigin, cols);
               morigin = (morigin + cols) % cells;
               scrolls_expected++;
            end
         end
         default: ;
      endcase
      send_byte(ch);
   endtask

   task automatic escape(input logic [7:0] code);
      case (code)
         "A": if (my > 0) my--;
         "B": if (my < rows - 1) my++;
         "C": if (mx < cols - 1) mx++;
         "D": if (mx > 0) mx--;
         "H": begin
            mx = 0;
            my = 0;
         end
         "K": blank_run(cursor_addr(), cols - mx);
         // from the cursor up to the cell before the origin
         "J": blank_run(cursor_addr(), (morigin - cursor_addr() - 1 + cells) % cells + 1);
         default: ;
      endcase
      send_byte(char_esc);
      send_byte(code);
   endtask

   task automatic go_to(input logic [7:0] row_byte, input logic [7:0] col_byte);
      int r;
      int c;
      r = int'(row_byte) - int'(pos_offset);
      c = int'(col_byte) - int'(pos_offset);
      if (r >= 0 && r < rows) begin
         my = r;
      end
      mx = (c >= 0 && c < cols) ? c : cols - 1;
      send_byte(char_esc);
      send_byte("Y");
      send_byte(row_byte);
      send_byte(col_byte);
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = 0;
      tests_run++;
   endtask

   task automatic end_test();
      if (test_errors == 0) begin
         $display("test %0d %s: ok", tests_run, test_name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, test_name, test_errors);
      end
   endtask

`include "tb_tests.svh"

   // budget grows with every byte sent and every erased cell
   initial begin
      while (cycle_count <= 200 * (bytes_sent + 1) + 2 * erase_cells + 50) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: the DUT stopped taking bytes after %0d clock cycles", cycle_count);
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      void'($urandom(73));
      clr    = 1'b1;
      px_clk = 1'b0;
      data   = 8'h00;
      valid  = 1'b0;
      for (int a = 0; a < cells; a++) begin
         screen[a]        = 8'(a * 3 + 8'h81);
         expect_screen[a] = 8'(a * 3 + 8'h81);
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      clr = 1'b0;
      run_tests();
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

/* terminal_if.sv */
// terminal interfaces: cursor command bus and character memory write request bus

interface cursor_cmd_if import terminal_pkg::*; #(
   parameter int rows = 25,
   parameter int cols = 80
) ();
   localparam int row_bits = $clog2(rows);
   localparam int col_bits = $clog2(cols);

   // one pulse per completed command
   logic                strobe;
   cmd_op_t             op;
   logic [7:0]          ch;
   logic [row_bits-1:0] row;
   logic                row_ok;
   logic [col_bits-1:0] col;

   modport source (output strobe, op, ch, row, row_ok, col);
   modport sink   (input  strobe, op, ch, row, row_ok, col);
endinterface

interface screen_write_if #(
   parameter int rows = 25,
   parameter int cols = 80
) ();
   localparam int addr_bits = $clog2(rows * cols);

   logic                 start;
   logic [7:0]           ch;
   logic [addr_bits-1:0] first;
   logic [addr_bits-1:0] last;
   // high while a run still has cells to write
   logic                 busy;

   modport source (output start, ch, first, last, input busy);
   modport sink   (input  start, ch, first, last, output busy);
endinterface

/* terminal_pkg.sv */
// terminal package: shared opcodes, decoder states and control-character codes
package terminal_pkg;

   // commands passed from the byte decoder to the cursor logic
   typedef enum logic [3:0] {
      op_put,
      op_bs,
      op_cr,
      op_lf,
      op_up,
      op_down,
      op_right,
      op_left,
      op_home,
      op_goto,
      op_erase_line,
      op_erase_screen
   } cmd_op_t;

   // byte parser states
   typedef enum logic [1:0] {
      st_char,
      st_esc,
      st_row,
      st_col
   } dec_state_t;

   // control characters understood in normal mode
   localparam logic [7:0] char_bs    = 8'h08;
   localparam logic [7:0] char_lf    = 8'h0a;
   localparam logic [7:0] char_cr    = 8'h0d;
   localparam logic [7:0] char_esc   = 8'h1b;

   // used to fill erased cells
   localparam logic [7:0] char_space = 8'h20;

   // printable range, inclusive on both ends
   localparam logic [7:0] char_first_print = 8'h20;
   localparam logic [7:0] char_last_print  = 8'h7e;

   // esc Y sends row and column biased by a space
   localparam logic [7:0] pos_offset = 8'h20;

endpackage
